//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_amber_system
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- amber_sys_pkg.sv
`default_nettype none

package amber_sys_pkg;

    // ----------------------------------------------------------
    // Bus widths and shared types
    // ----------------------------------------------------------
    localparam int WB_DWIDTH = 32;
    localparam int WB_SWIDTH = 4;

    typedef logic [31:0]          wb_adr_t;
    typedef logic [WB_DWIDTH-1:0] wb_dat_t;
    typedef logic [WB_SWIDTH-1:0] wb_sel_t;
    typedef logic [3:0]           led_t;
    typedef logic [15:0]          timer_cnt_t;

    // Bit 0 test irq, bit 1 test firq, bits 4:2 timers 0 to 2
    typedef logic [4:0]           irq_src_t;

    // Bit 0 boot, 1 test, 2 timer, 3 interrupt controller
    typedef logic [3:0]           slave_stb_t;

    // ----------------------------------------------------------
    // Address map, compared against address bits 31:24
    // ----------------------------------------------------------
    localparam logic [7:0] REGION_BOOT  = 8'h00;
    localparam logic [7:0] REGION_TIMER = 8'h13;
    localparam logic [7:0] REGION_INTC  = 8'h14;
    localparam logic [7:0] REGION_TEST  = 8'hF0;

    // Boot memory decodes address bits 10:2 only
    localparam int BOOT_MEM_WORDS = 512;

    localparam int NUM_TIMERS   = 3;
    localparam int TIMER_STRIDE = 'h100;

    // ----------------------------------------------------------
    // Register offsets, compared against address bits 7:0
    // ----------------------------------------------------------
    localparam logic [7:0] TIMER_LOAD     = 8'h00;
    localparam logic [7:0] TIMER_VALUE    = 8'h04;
    localparam logic [7:0] TIMER_CTRL     = 8'h08;
    localparam logic [7:0] TIMER_CLEAR    = 8'h0C;

    localparam logic [7:0] TEST_LED       = 8'h00;
    localparam logic [7:0] TEST_IRQ       = 8'h04;
    localparam logic [7:0] TEST_FIRQ      = 8'h08;

    localparam logic [7:0] IC_IRQ_STATUS  = 8'h00;
    localparam logic [7:0] IC_IRQ_RAW     = 8'h04;
    localparam logic [7:0] IC_IRQ_EN_SET  = 8'h08;
    localparam logic [7:0] IC_IRQ_EN_CLR  = 8'h0C;
    localparam logic [7:0] IC_FIRQ_STATUS = 8'h10;
    localparam logic [7:0] IC_FIRQ_EN_SET = 8'h14;
    localparam logic [7:0] IC_FIRQ_EN_CLR = 8'h18;

endpackage

`default_nettype wire

//--- amber_system.sv
`timescale 1ns/1ns
`default_nettype none

module amber_system (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  wire amber_sys_pkg::wb_sel_t  i_wb_sel,
    input  wire                          i_wb_we,
    input  wire amber_sys_pkg::wb_dat_t  i_wb_dat,
    input  wire                          i_wb_cyc,
    input  wire                          i_wb_stb,
    output amber_sys_pkg::wb_dat_t       o_wb_dat,
    output logic                         o_wb_ack,
    output logic                         o_wb_err,
    output logic                         o_irq,
    output logic                         o_firq,
    output amber_sys_pkg::led_t          o_led
);

    amber_sys_pkg::slave_stb_t                slave_stb;
    amber_sys_pkg::slave_stb_t                slave_ack;
    amber_sys_pkg::wb_dat_t                   boot_dat;
    amber_sys_pkg::wb_dat_t                   test_dat;
    amber_sys_pkg::wb_dat_t                   timer_dat;
    amber_sys_pkg::wb_dat_t                   intc_dat;
    logic                                     test_irq;
    logic                                     test_firq;
    logic [amber_sys_pkg::NUM_TIMERS-1:0]     timer_int;

    // ----------------------------------------------------------
    // Address decode and return path
    // ----------------------------------------------------------
    wb_decoder u_wb_decoder (
        .i_clk          ( i_clk          ),
        .i_reset        ( i_reset        ),
        .i_wb_adr       ( i_wb_adr       ),
        .i_wb_cyc       ( i_wb_cyc       ),
        .i_wb_stb       ( i_wb_stb       ),
        .i_slave_ack    ( slave_ack      ),
        .i_boot_dat     ( boot_dat       ),
        .i_test_dat     ( test_dat       ),
        .i_timer_dat    ( timer_dat      ),
        .i_intc_dat     ( intc_dat       ),
        .o_slave_stb    ( slave_stb      ),
        .o_wb_dat       ( o_wb_dat       ),
        .o_wb_ack       ( o_wb_ack       ),
        .o_wb_err       ( o_wb_err       )
    );

    // ----------------------------------------------------------
    // Slaves, strobe and ack bits in decoder order
    // ----------------------------------------------------------
    boot_mem u_boot_mem (
        .i_clk          ( i_clk          ),
        .i_reset        ( i_reset        ),
        .i_stb          ( slave_stb[0]   ),
        .i_wb_we        ( i_wb_we        ),
        .i_wb_sel       ( i_wb_sel       ),
        .i_wb_adr       ( i_wb_adr       ),
        .i_wb_dat       ( i_wb_dat       ),
        .o_wb_dat       ( boot_dat       ),
        .o_ack          ( slave_ack[0]   )
    );

    test_module u_test_module (
        .i_clk          ( i_clk          ),
        .i_reset        ( i_reset        ),
        .i_stb          ( slave_stb[1]   ),
        .i_wb_we        ( i_wb_we        ),
        .i_wb_adr       ( i_wb_adr       ),
        .i_wb_dat       ( i_wb_dat       ),
        .o_wb_dat       ( test_dat       ),
        .o_ack          ( slave_ack[1]   ),
        .o_led          ( o_led          ),
        .o_test_irq     ( test_irq       ),
        .o_test_firq    ( test_firq      )
    );

    timer_module u_timer_module (
        .i_clk          ( i_clk          ),
        .i_reset        ( i_reset        ),
        .i_stb          ( slave_stb[2]   ),
        .i_wb_we        ( i_wb_we        ),
        .i_wb_adr       ( i_wb_adr       ),
        .i_wb_dat       ( i_wb_dat       ),
        .o_wb_dat       ( timer_dat      ),
        .o_ack          ( slave_ack[2]   ),
        .o_timer_int    ( timer_int      )
    );

    interrupt_controller u_interrupt_controller (
        .i_clk          ( i_clk          ),
        .i_reset        ( i_reset        ),
        .i_stb          ( slave_stb[3]   ),
        .i_wb_we        ( i_wb_we        ),
        .i_wb_adr       ( i_wb_adr       ),
        .i_wb_dat       ( i_wb_dat       ),
        .i_test_irq     ( test_irq       ),
        .i_test_firq    ( test_firq      ),
        .i_timer_int    ( timer_int      ),
        .o_wb_dat       ( intc_dat       ),
        .o_ack          ( slave_ack[3]   ),
        .o_irq          ( o_irq          ),
        .o_firq         ( o_firq         )
    );

endmodule

`default_nettype wire

//--- amber_system_sva.sv
`timescale 1ns/1ns
`default_nettype none

module amber_system_sva (
    input wire i_clk,
    input wire i_reset,
    input wire i_wb_cyc,
    input wire i_wb_stb,
    input wire o_wb_ack,
    input wire o_wb_err
);

    // An access ends in ack or err, never both
    ack_err_exclusive: assert property (
        @(posedge i_clk) disable iff (i_reset) !(o_wb_ack && o_wb_err)
    ) else $error("ack and err were high in the same cycle");

    // Responses only while the master holds its request
    response_in_cycle: assert property (
        @(posedge i_clk) disable iff (i_reset)
            (o_wb_ack || o_wb_err) |-> (i_wb_cyc && i_wb_stb)
    ) else $error("response seen without cyc and stb high");

    ack_single_cycle: assert property (
        @(posedge i_clk) disable iff (i_reset) o_wb_ack |=> !o_wb_ack
    ) else $error("ack stayed high for two cycles");

endmodule

bind amber_system amber_system_sva u_sva (
    .i_clk    ( i_clk    ),
    .i_reset  ( i_reset  ),
    .i_wb_cyc ( i_wb_cyc ),
    .i_wb_stb ( i_wb_stb ),
    .o_wb_ack ( o_wb_ack ),
    .o_wb_err ( o_wb_err )
);

`default_nettype wire

//--- boot_mem.sv
`timescale 1ns/1ns
`default_nettype none

module boot_mem (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_stb,
    input  wire                          i_wb_we,
    input  wire amber_sys_pkg::wb_sel_t  i_wb_sel,
    input  wire amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  wire amber_sys_pkg::wb_dat_t  i_wb_dat,
    output amber_sys_pkg::wb_dat_t       o_wb_dat,
    output logic                         o_ack
);

    localparam int IDX_W = $clog2(amber_sys_pkg::BOOT_MEM_WORDS);

    amber_sys_pkg::wb_dat_t mem [amber_sys_pkg::BOOT_MEM_WORDS];
    logic [IDX_W-1:0]       word_idx;
    logic                   stb_d;
    logic                   access;

    // Word index from bits 10:2, higher bits alias
    assign word_idx = i_wb_adr[2 +: IDX_W];
    assign access   = i_stb && !stb_d;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stb_d <= 1'b0;
            o_ack <= 1'b0;
        end else begin
            stb_d <= i_stb;
            o_ack <= access;
        end
    end

    // Byte-lane writes; read word is registered for the ack cycle
    always_ff @(posedge i_clk) begin
        if (access) begin
            if (i_wb_we) begin
                for (int b = 0; b < amber_sys_pkg::WB_SWIDTH; b++) begin
                    if (i_wb_sel[b]) begin
                        mem[word_idx][8*b +: 8] <= i_wb_dat[8*b +: 8];
                    end
                end
            end
            o_wb_dat <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

//--- interrupt_controller.sv
`timescale 1ns/1ns
`default_nettype none

module interrupt_controller (
    input  wire                                   i_clk,
    input  wire                                   i_reset,
    input  wire                                   i_stb,
    input  wire                                   i_wb_we,
    input  wire amber_sys_pkg::wb_adr_t           i_wb_adr,
    input  wire amber_sys_pkg::wb_dat_t           i_wb_dat,
    input  wire                                   i_test_irq,
    input  wire                                   i_test_firq,
    input  wire [amber_sys_pkg::NUM_TIMERS-1:0]   i_timer_int,
    output amber_sys_pkg::wb_dat_t                o_wb_dat,
    output logic                                  o_ack,
    output logic                                  o_irq,
    output logic                                  o_firq
);

    amber_sys_pkg::irq_src_t raw;
    amber_sys_pkg::irq_src_t wr_bits;
    amber_sys_pkg::irq_src_t irq_en_q;
    amber_sys_pkg::irq_src_t firq_en_q;
    amber_sys_pkg::irq_src_t irq_status;
    amber_sys_pkg::irq_src_t firq_status;
    logic [7:0]              offset;
    logic                    stb_d;
    logic                    access;
    logic                    wr_en;

    assign raw         = {i_timer_int, i_test_firq, i_test_irq};
    assign wr_bits     = amber_sys_pkg::irq_src_t'(i_wb_dat);
    assign irq_status  = raw & irq_en_q;
    assign firq_status = raw & firq_en_q;

    assign offset = i_wb_adr[7:0];
    assign access = i_stb && !stb_d;
    assign wr_en  = access && i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stb_d     <= 1'b0;
            o_ack     <= 1'b0;
            irq_en_q  <= '0;
            firq_en_q <= '0;
            o_irq     <= 1'b0;
            o_firq    <= 1'b0;
        end else begin
            stb_d  <= i_stb;
            o_ack  <= access;
            o_irq  <= |irq_status;
            o_firq <= |firq_status;
            if (wr_en) begin
                case (offset)
                    amber_sys_pkg::IC_IRQ_EN_SET:  irq_en_q  <= irq_en_q | wr_bits;
                    amber_sys_pkg::IC_IRQ_EN_CLR:  irq_en_q  <= irq_en_q & ~wr_bits;
                    amber_sys_pkg::IC_FIRQ_EN_SET: firq_en_q <= firq_en_q | wr_bits;
                    amber_sys_pkg::IC_FIRQ_EN_CLR: firq_en_q <= firq_en_q & ~wr_bits;
                    default: ;
                endcase
            end
        end
    end

    // SET offsets read back the current mask
    always_comb begin
        case (offset)
            amber_sys_pkg::IC_IRQ_STATUS:  o_wb_dat = amber_sys_pkg::wb_dat_t'(irq_status);
            amber_sys_pkg::IC_IRQ_RAW:     o_wb_dat = amber_sys_pkg::wb_dat_t'(raw);
            amber_sys_pkg::IC_IRQ_EN_SET:  o_wb_dat = amber_sys_pkg::wb_dat_t'(irq_en_q);
            amber_sys_pkg::IC_FIRQ_STATUS: o_wb_dat = amber_sys_pkg::wb_dat_t'(firq_status);
            amber_sys_pkg::IC_FIRQ_EN_SET: o_wb_dat = amber_sys_pkg::wb_dat_t'(firq_en_q);
            default:                       o_wb_dat = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- tb_amber_system.sv
`timescale 1ns/1ns
`default_nettype none

module tb_amber_system;

    localparam logic [2:0] OP_WRITE   = 3'd0;
    localparam logic [2:0] OP_READ    = 3'd1;
    localparam logic [2:0] OP_READ_LE = 3'd2;
    localparam logic [2:0] OP_PINS    = 3'd3;
    localparam logic [2:0] OP_WAIT    = 3'd4;
    localparam logic       RSP_ACK    = 1'b0;
    localparam logic       RSP_ERR    = 1'b1;

    localparam int MAX_TIMER_LOAD = 20;
    localparam int IRQ_WAIT_LIMIT = 40;
    localparam int ACCESS_LIMIT   = 16;

    // Register addresses as seen from the bus
    localparam logic [31:0] TEST_LED_ADR  = 32'hF000_0000;
    localparam logic [31:0] TEST_IRQ_ADR  = 32'hF000_0004;
    localparam logic [31:0] TEST_FIRQ_ADR = 32'hF000_0008;
    localparam logic [31:0] T1_LOAD_ADR   = 32'h1300_0100;
    localparam logic [31:0] T1_VALUE_ADR  = 32'h1300_0104;
    localparam logic [31:0] T1_CTRL_ADR   = 32'h1300_0108;
    localparam logic [31:0] T1_CLEAR_ADR  = 32'h1300_010C;
    localparam logic [31:0] IC_STAT_ADR   = 32'h1400_0000;
    localparam logic [31:0] IC_RAW_ADR    = 32'h1400_0004;
    localparam logic [31:0] IC_SET_ADR    = 32'h1400_0008;
    localparam logic [31:0] IC_CLR_ADR    = 32'h1400_000C;
    localparam logic [31:0] IC_FSTAT_ADR  = 32'h1400_0010;
    localparam logic [31:0] IC_FSET_ADR   = 32'h1400_0014;
    localparam logic [31:0] IC_FCLR_ADR   = 32'h1400_0018;

    typedef struct packed {
        logic [2:0]             op;
        amber_sys_pkg::wb_adr_t adr;
        amber_sys_pkg::wb_sel_t sel;
        amber_sys_pkg::wb_dat_t wdat;
        amber_sys_pkg::wb_dat_t exp;
        logic                   rsp;
    } entry_t;

    logic                   i_clk;
    logic                   i_reset;
    amber_sys_pkg::wb_adr_t i_wb_adr;
    amber_sys_pkg::wb_sel_t i_wb_sel;
    logic                   i_wb_we;
    amber_sys_pkg::wb_dat_t i_wb_dat;
    logic                   i_wb_cyc;
    logic                   i_wb_stb;
    amber_sys_pkg::wb_dat_t o_wb_dat;
    logic                   o_wb_ack;
    logic                   o_wb_err;
    logic                   o_irq;
    logic                   o_firq;
    amber_sys_pkg::led_t    o_led;

    entry_t table_q[$];
    integer seed;
    int     error_count;
    int     check_count;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    amber_system u_dut (
        .i_clk    ( i_clk    ),
        .i_reset  ( i_reset  ),
        .i_wb_adr ( i_wb_adr ),
        .i_wb_sel ( i_wb_sel ),
        .i_wb_we  ( i_wb_we  ),
        .i_wb_dat ( i_wb_dat ),
        .i_wb_cyc ( i_wb_cyc ),
        .i_wb_stb ( i_wb_stb ),
        .o_wb_dat ( o_wb_dat ),
        .o_wb_ack ( o_wb_ack ),
        .o_wb_err ( o_wb_err ),
        .o_irq    ( o_irq    ),
        .o_firq   ( o_firq   ),
        .o_led    ( o_led    )
    );

    initial begin
        i_clk = 1'b0;
        forever #50 i_clk = ~i_clk;
    end

    // Run limit, sized from the table once it is built
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            $display("Timeout: the run passed its limit of %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Reference model of a byte-select write
    function automatic amber_sys_pkg::wb_dat_t merge_bytes(
        input amber_sys_pkg::wb_dat_t old_word,
        input amber_sys_pkg::wb_dat_t new_word,
        input amber_sys_pkg::wb_sel_t sel
    );
        amber_sys_pkg::wb_dat_t result;
        result = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                result[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return result;
    endfunction

    function automatic void add_entry(
        input logic [2:0]             op,
        input amber_sys_pkg::wb_adr_t adr,
        input amber_sys_pkg::wb_sel_t sel,
        input amber_sys_pkg::wb_dat_t wdat,
        input amber_sys_pkg::wb_dat_t exp,
        input logic                   rsp
    );
        entry_t e;
        e.op   = op;
        e.adr  = adr;
        e.sel  = sel;
        e.wdat = wdat;
        e.exp  = exp;
        e.rsp  = rsp;
        table_q.push_back(e);
    endfunction

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    task automatic build_table();
        amber_sys_pkg::wb_dat_t w0;
        amber_sys_pkg::wb_dat_t w1;
        amber_sys_pkg::wb_dat_t w2;
        amber_sys_pkg::wb_dat_t w3;
        amber_sys_pkg::wb_dat_t w4;
        amber_sys_pkg::wb_dat_t word_10;
        amber_sys_pkg::wb_dat_t word_24;
        w0 = $random(seed);
        w1 = $random(seed);
        w2 = $random(seed);
        w3 = $random(seed);
        w4 = $random(seed);
        word_10 = merge_bytes(w0, w1, 4'b0101);
        word_24 = merge_bytes(merge_bytes(w2, w3, 4'b1000), w4, 4'b0010);
        // Boot memory, with aliased accesses through bit 11 and bit 12
        add_entry(OP_WRITE, 32'h0000_0010, 4'b1111, w0, '0, RSP_ACK);
        add_entry(OP_WRITE, 32'h0000_0010, 4'b0101, w1, '0, RSP_ACK);
        add_entry(OP_READ,  32'h0000_0010, 4'b1111, '0, word_10, RSP_ACK);
        add_entry(OP_READ,  32'h0000_0810, 4'b1111, '0, word_10, RSP_ACK);
        add_entry(OP_WRITE, 32'h0000_0024, 4'b1111, w2, '0, RSP_ACK);
        add_entry(OP_WRITE, 32'h0000_0024, 4'b1000, w3, '0, RSP_ACK);
        add_entry(OP_WRITE, 32'h0000_1024, 4'b0010, w4, '0, RSP_ACK);
        add_entry(OP_READ,  32'h0000_0024, 4'b1111, '0, word_24, RSP_ACK);
        // LEDs and an unmapped region
        add_entry(OP_WRITE, TEST_LED_ADR, 4'b1111, 32'hA5, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_READ,  TEST_LED_ADR, 4'b1111, '0, 32'h5, RSP_ACK);
        add_entry(OP_WRITE, 32'h2000_0000, 4'b1111, 32'h1, '0, RSP_ERR);
        add_entry(OP_READ,  32'h2000_0004, 4'b1111, '0, '0, RSP_ERR);
        // Test irq through the irq mask
        add_entry(OP_WRITE, TEST_IRQ_ADR, 4'b1111, 32'h1, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_READ,  IC_RAW_ADR, 4'b1111, '0, 32'h01, RSP_ACK);
        add_entry(OP_WRITE, IC_SET_ADR, 4'b1111, 32'h01, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h15, RSP_ACK);
        add_entry(OP_READ,  IC_STAT_ADR, 4'b1111, '0, 32'h01, RSP_ACK);
        add_entry(OP_WRITE, IC_CLR_ADR, 4'b1111, 32'h01, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_WRITE, TEST_IRQ_ADR, 4'b1111, 32'h0, '0, RSP_ACK);
        // Test firq through the firq mask
        add_entry(OP_WRITE, TEST_FIRQ_ADR, 4'b1111, 32'h1, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_WRITE, IC_FSET_ADR, 4'b1111, 32'h02, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h25, RSP_ACK);
        add_entry(OP_READ,  IC_FSTAT_ADR, 4'b1111, '0, 32'h02, RSP_ACK);
        add_entry(OP_WRITE, IC_FCLR_ADR, 4'b1111, 32'h02, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_WRITE, TEST_FIRQ_ADR, 4'b1111, 32'h0, '0, RSP_ACK);
        // Timer 1 into irq bit 3
        add_entry(OP_WRITE, T1_LOAD_ADR, 4'b1111, MAX_TIMER_LOAD, '0, RSP_ACK);
        add_entry(OP_WRITE, IC_SET_ADR, 4'b1111, 32'h08, '0, RSP_ACK);
        add_entry(OP_WRITE, T1_CTRL_ADR, 4'b1111, 32'h80, '0, RSP_ACK);
        add_entry(OP_WAIT,  '0, '0, IRQ_WAIT_LIMIT, '0, RSP_ACK);
        add_entry(OP_READ,  IC_RAW_ADR, 4'b1111, '0, 32'h08, RSP_ACK);
        add_entry(OP_READ_LE, T1_VALUE_ADR, 4'b1111, '0, MAX_TIMER_LOAD, RSP_ACK);
        add_entry(OP_WRITE, T1_CTRL_ADR, 4'b1111, 32'h0, '0, RSP_ACK);
        add_entry(OP_WRITE, T1_CLEAR_ADR, 4'b1111, 32'h1, '0, RSP_ACK);
        add_entry(OP_PINS,  '0, '0, '0, 32'h05, RSP_ACK);
        add_entry(OP_READ,  IC_RAW_ADR, 4'b1111, '0, 32'h00, RSP_ACK);
    endtask

    // ----------------------------------------------------------
    // Bus access and checks
    // ----------------------------------------------------------
    task automatic bus_access(
        input  logic                   we,
        input  amber_sys_pkg::wb_adr_t adr,
        input  amber_sys_pkg::wb_sel_t sel,
        input  amber_sys_pkg::wb_dat_t wdat,
        output amber_sys_pkg::wb_dat_t rdata,
        output logic                   got_ack,
        output logic                   got_err
    );
        int waited;
        waited = 0;
        @(posedge i_clk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= adr;
        i_wb_sel <= sel;
        i_wb_dat <= wdat;
        @(negedge i_clk);
        while (!o_wb_ack && !o_wb_err && waited < ACCESS_LIMIT) begin
            waited++;
            @(negedge i_clk);
        end
        rdata   = o_wb_dat;
        got_ack = o_wb_ack;
        got_err = o_wb_err;
        @(posedge i_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
    endtask

    // Outputs are registered, so look one clock after the access
    task automatic check_pins(input logic [5:0] exp_pins, input int index);
        logic [5:0] pins;
        @(posedge i_clk);
        @(negedge i_clk);
        pins = {o_firq, o_irq, o_led};
        check_count++;
        assert (pins == exp_pins) else begin
            error_count++;
            $display("Error at %0t: entry %0d firq/irq/led is %b, expected %b",
                     $time, index, pins, exp_pins);
        end
    endtask

    task automatic wait_for_irq(input int limit, input int index);
        int waited;
        waited = 0;
        @(negedge i_clk);
        while (!o_irq && waited < limit) begin
            waited++;
            @(negedge i_clk);
        end
        check_count++;
        assert (o_irq) else begin
            error_count++;
            $display("Entry %0d: o_irq did not rise within %0d cycles", index, limit);
        end
    endtask

    task automatic apply_entry(input entry_t e, input int index);
        amber_sys_pkg::wb_dat_t rdata;
        logic                   got_ack;
        logic                   got_err;
        case (e.op)
            OP_PINS: check_pins(e.exp[5:0], index);
            OP_WAIT: wait_for_irq(int'(e.wdat), index);
            default: begin
                bus_access(e.op == OP_WRITE, e.adr, e.sel, e.wdat, rdata, got_ack, got_err);
                check_count++;
                assert (got_ack == (e.rsp == RSP_ACK) && got_err == (e.rsp == RSP_ERR)) else begin
                    error_count++;
                    $display("Error at %0t: entry %0d ended with ack=%0b err=%0b",
                             $time, index, got_ack, got_err);
                end
                if (e.op == OP_READ && got_ack) begin
                    assert (rdata == e.exp) else begin
                        error_count++;
                        $display("Error at %0t: entry %0d read 0x%08h, expected 0x%08h",
                                 $time, index, rdata, e.exp);
                    end
                end
                if (e.op == OP_READ_LE && got_ack) begin
                    assert (rdata <= e.exp) else begin
                        error_count++;
                        $display("Error at %0t: entry %0d read 0x%08h, above 0x%08h",
                                 $time, index, rdata, e.exp);
                    end
                end
            end
        endcase
    endtask

    initial begin
        error_count = 0;
        check_count = 0;
        seed        = 11411;
        i_reset     = 1'b1;
        i_wb_adr    = '0;
        i_wb_sel    = '0;
        i_wb_we     = 1'b0;
        i_wb_dat    = '0;
        i_wb_cyc    = 1'b0;
        i_wb_stb    = 1'b0;
        build_table();
        cycle_limit = 4 * table_q.size() + MAX_TIMER_LOAD + 200;
        repeat (4) @(posedge i_clk);
        i_reset <= 1'b0;

        // Everything idle straight after reset
        @(negedge i_clk);
        check_count++;
        assert (o_led == '0 && !o_irq && !o_firq && !o_wb_ack && !o_wb_err) else begin
            error_count++;
            $display("Error at %0t: outputs not idle after reset", $time);
        end

        foreach (table_q[i]) begin
            apply_entry(table_q[i], i);
        end
        repeat (2) @(posedge i_clk);

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- test_module.sv
`timescale 1ns/1ns
`default_nettype none

module test_module (
    input  wire                          i_clk,
    input  wire                          i_reset,
    input  wire                          i_stb,
    input  wire                          i_wb_we,
    input  wire amber_sys_pkg::wb_adr_t  i_wb_adr,
    input  wire amber_sys_pkg::wb_dat_t  i_wb_dat,
    output amber_sys_pkg::wb_dat_t       o_wb_dat,
    output logic                         o_ack,
    output amber_sys_pkg::led_t          o_led,
    output logic                         o_test_irq,
    output logic                         o_test_firq
);

    logic [7:0] offset;
    logic       stb_d;
    logic       access;
    logic       wr_en;

    assign offset = i_wb_adr[7:0];
    assign access = i_stb && !stb_d;
    assign wr_en  = access && i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stb_d       <= 1'b0;
            o_ack       <= 1'b0;
            o_led       <= '0;
            o_test_irq  <= 1'b0;
            o_test_firq <= 1'b0;
        end else begin
            stb_d <= i_stb;
            o_ack <= access;
            if (wr_en) begin
                case (offset)
                    amber_sys_pkg::TEST_LED:  o_led       <= amber_sys_pkg::led_t'(i_wb_dat);
                    amber_sys_pkg::TEST_IRQ:  o_test_irq  <= i_wb_dat[0];
                    amber_sys_pkg::TEST_FIRQ: o_test_firq <= i_wb_dat[0];
                    default: ;
                endcase
            end
        end
    end

    // Unknown offsets read as zero
    always_comb begin
        o_wb_dat = '0;
        case (offset)
            amber_sys_pkg::TEST_LED:  o_wb_dat = amber_sys_pkg::wb_dat_t'(o_led);
            amber_sys_pkg::TEST_IRQ:  o_wb_dat[0] = o_test_irq;
            amber_sys_pkg::TEST_FIRQ: o_wb_dat[0] = o_test_firq;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- timer_module.sv
`timescale 1ns/1ns
`default_nettype none

module timer_module (
    input  wire                                  i_clk,
    input  wire                                  i_reset,
    input  wire                                  i_stb,
    input  wire                                  i_wb_we,
    input  wire amber_sys_pkg::wb_adr_t          i_wb_adr,
    input  wire amber_sys_pkg::wb_dat_t          i_wb_dat,
    output amber_sys_pkg::wb_dat_t               o_wb_dat,
    output logic                                 o_ack,
    output logic [amber_sys_pkg::NUM_TIMERS-1:0] o_timer_int
);

    localparam int N       = amber_sys_pkg::NUM_TIMERS;
    localparam int SEL_LSB = $clog2(amber_sys_pkg::TIMER_STRIDE);

    amber_sys_pkg::timer_cnt_t load_q  [N];
    amber_sys_pkg::timer_cnt_t count_q [N];
    logic [N-1:0]              enable_q;
    logic [N-1:0]              flag_q;
    logic [1:0]                sel;
    logic [7:0]                offset;
    logic                      stb_d;
    logic                      access;
    logic                      wr_en;

    // Address bits 9:8 pick the timer
    assign sel    = i_wb_adr[SEL_LSB +: 2];
    assign offset = i_wb_adr[7:0];
    assign access = i_stb && !stb_d;
    assign wr_en  = access && i_wb_we;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            stb_d    <= 1'b0;
            o_ack    <= 1'b0;
            enable_q <= '0;
            flag_q   <= '0;
            for (int i = 0; i < N; i++) begin
                load_q[i]  <= '0;
                count_q[i] <= '0;
            end
        end else begin
            stb_d <= i_stb;
            o_ack <= access;
            for (int i = 0; i < N; i++) begin
                // Reload and flag on the clock that would pass zero
                if (enable_q[i]) begin
                    if (count_q[i] == '0) begin
                        count_q[i] <= load_q[i];
                        flag_q[i]  <= 1'b1;
                    end else begin
                        count_q[i] <= count_q[i] - 1'b1;
                    end
                end
                // Bus writes win over the counter
                if (wr_en && sel == 2'(i)) begin
                    case (offset)
                        amber_sys_pkg::TIMER_LOAD: begin
                            load_q[i]  <= amber_sys_pkg::timer_cnt_t'(i_wb_dat);
                            count_q[i] <= amber_sys_pkg::timer_cnt_t'(i_wb_dat);
                        end
                        amber_sys_pkg::TIMER_CTRL:  enable_q[i] <= i_wb_dat[7];
                        amber_sys_pkg::TIMER_CLEAR: flag_q[i]   <= 1'b0;
                        default: ;
                    endcase
                end
            end
        end
    end

    // VALUE reads the live count, CLEAR reads back the flag
    always_comb begin
        o_wb_dat = '0;
        if (sel < 2'(N)) begin
            case (offset)
                amber_sys_pkg::TIMER_LOAD:  o_wb_dat = amber_sys_pkg::wb_dat_t'(load_q[sel]);
                amber_sys_pkg::TIMER_VALUE: o_wb_dat = amber_sys_pkg::wb_dat_t'(count_q[sel]);
                amber_sys_pkg::TIMER_CTRL:  o_wb_dat[7] = enable_q[sel];
                amber_sys_pkg::TIMER_CLEAR: o_wb_dat[0] = flag_q[sel];
                default: ;
            endcase
        end
    end

    assign o_timer_int = flag_q;

endmodule

`default_nettype wire

//--- verilog.f
amber_sys_pkg.sv
wb_decoder.sv
boot_mem.sv
test_module.sv
timer_module.sv
interrupt_controller.sv
amber_system.sv
amber_system_sva.sv
tb_amber_system.sv

//--- wb_decoder.sv
`timescale 1ns/1ns
`default_nettype none

module wb_decoder (
    input  wire                             i_clk,
    input  wire                             i_reset,
    input  wire amber_sys_pkg::wb_adr_t     i_wb_adr,
    input  wire                             i_wb_cyc,
    input  wire                             i_wb_stb,
    input  wire amber_sys_pkg::slave_stb_t  i_slave_ack,
    input  wire amber_sys_pkg::wb_dat_t     i_boot_dat,
    input  wire amber_sys_pkg::wb_dat_t     i_test_dat,
    input  wire amber_sys_pkg::wb_dat_t     i_timer_dat,
    input  wire amber_sys_pkg::wb_dat_t     i_intc_dat,
    output amber_sys_pkg::slave_stb_t       o_slave_stb,
    output amber_sys_pkg::wb_dat_t          o_wb_dat,
    output logic                            o_wb_ack,
    output logic                            o_wb_err
);

    logic [7:0] region;
    logic       bus_req;
    logic       unmapped;
    logic       unmapped_d;

    assign region  = i_wb_adr[31:24];
    assign bus_req = i_wb_cyc && i_wb_stb;

    // One strobe per slave, anything else is unmapped
    always_comb begin
        o_slave_stb = '0;
        unmapped    = 1'b0;
        case (region)
            amber_sys_pkg::REGION_BOOT:  o_slave_stb[0] = bus_req;
            amber_sys_pkg::REGION_TEST:  o_slave_stb[1] = bus_req;
            amber_sys_pkg::REGION_TIMER: o_slave_stb[2] = bus_req;
            amber_sys_pkg::REGION_INTC:  o_slave_stb[3] = bus_req;
            default:                     unmapped       = bus_req;
        endcase
    end

    // Read data follows the region of the held address
    always_comb begin
        case (region)
            amber_sys_pkg::REGION_BOOT:  o_wb_dat = i_boot_dat;
            amber_sys_pkg::REGION_TEST:  o_wb_dat = i_test_dat;
            amber_sys_pkg::REGION_TIMER: o_wb_dat = i_timer_dat;
            amber_sys_pkg::REGION_INTC:  o_wb_dat = i_intc_dat;
            default:                     o_wb_dat = '0;
        endcase
    end

    assign o_wb_ack = |i_slave_ack;

    // Error pulse, same timing as a slave ack
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            unmapped_d <= 1'b0;
            o_wb_err   <= 1'b0;
        end else begin
            unmapped_d <= unmapped;
            o_wb_err   <= unmapped && !unmapped_d;
        end
    end

endmodule

`default_nettype wire
